/* hdl/calc_config.svh */
// calculator configuration constants
// register, column and delay line sizes plus keyboard settle time

`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// working registers on the delay line, entry and accumulator
`define CALC_NUM_REGS 2

// digits per register
`define CALC_NUM_COLS 16

// one slot per digit of every register
`define CALC_DL_LENGTH (`CALC_NUM_REGS * `CALC_NUM_COLS)

// cycles a key is held before it counts as pressed
`define CALC_KEY_DELAY 8

`endif

/* hdl/calc_pkg.sv */
// calculator datapath types
// digit codes, delay line slot tags, opcodes and Johnson/BCD conversion

`include "calc_config.svh"

package calc_pkg;

    typedef logic [3:0] digit_t;
    typedef logic [4:0] johnson_t;
    typedef logic [3:0] col_t;

    typedef enum logic {
        REG_ENTRY,
        REG_ACC
    } reg_sel_e;

    // rev_start marks entry column 0, the first slot of a revolution
    typedef struct packed {
        reg_sel_e reg_sel;
        col_t     col;
        logic     rev_start;
    } slot_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_DIGIT,
        OP_CLR_ENT,
        OP_CLR_ALL,
        OP_ENTER,
        OP_ADD
    } op_e;

    typedef struct packed {
        op_e    op;
        digit_t digit;
    } op_cmd_t;

    // column 0 sits in the low nibble
    typedef digit_t [`CALC_NUM_COLS-1:0] digits_t;

    // ring counter fills with ones from the bottom, then empties
    function automatic johnson_t to_johnson(input digit_t d);
        case (d)
            4'd1:    return 5'b00001;
            4'd2:    return 5'b00011;
            4'd3:    return 5'b00111;
            4'd4:    return 5'b01111;
            4'd5:    return 5'b11111;
            4'd6:    return 5'b11110;
            4'd7:    return 5'b11100;
            4'd8:    return 5'b11000;
            4'd9:    return 5'b10000;
            default: return 5'b00000;
        endcase
    endfunction

    // illegal ring states read back as hex F
    function automatic digit_t to_bcd(input johnson_t j);
        case (j)
            5'b00000: return 4'd0;
            5'b00001: return 4'd1;
            5'b00011: return 4'd2;
            5'b00111: return 4'd3;
            5'b01111: return 4'd4;
            5'b11111: return 4'd5;
            5'b11110: return 4'd6;
            5'b11100: return 4'd7;
            5'b11000: return 4'd8;
            5'b10000: return 4'd9;
            default:  return 4'hf;
        endcase
    endfunction

endpackage

/* hdl/kbd_pkg.sv */
// keyboard key codes
// one held key at a time, KEY_NONE when the keyboard is idle

package kbd_pkg;

    // digit keys are consecutive so the digit is an offset from KEY_0
    typedef enum logic [3:0] {
        KEY_NONE,
        KEY_0,
        KEY_1,
        KEY_2,
        KEY_3,
        KEY_4,
        KEY_5,
        KEY_6,
        KEY_7,
        KEY_8,
        KEY_9,
        KEY_CLR_ENT,
        KEY_CLR_ALL,
        KEY_ENTER,
        KEY_ADD
    } key_e;

endpackage

/* hdl/keyboard_scanner.sv */
// keyboard scanner
// settles a held key and gives one acknowledge and command per press

`timescale 1ns/1ps
`include "calc_config.svh"

module keyboard_scanner (
    input  logic              clk,
    input  logic              h_sc_rst,
    input  kbd_pkg::key_e     i_key,
    input  logic              i_lock,
    output logic              o_kbd_ack,
    output calc_pkg::op_cmd_t o_cmd
);

    localparam int CNT_W = $clog2(`CALC_KEY_DELAY + 1);

    kbd_pkg::key_e    prev_key;
    logic [CNT_W-1:0] settle_cnt;
    logic [CNT_W-1:0] held_cnt;
    logic             key_released;
    logic             key_down;

    assign key_down = (i_key != kbd_pkg::KEY_NONE);

    // a different key restarts the settle time
    assign held_cnt = (i_key == prev_key) ? settle_cnt : '0;

    assign o_kbd_ack = key_down && key_released && !i_lock
                       && (held_cnt == CNT_W'(`CALC_KEY_DELAY - 1));

    always_ff @(posedge clk) begin
        if (h_sc_rst) begin
            prev_key     <= kbd_pkg::KEY_NONE;
            settle_cnt   <= '0;
            key_released <= 1'b1;
        end else begin
            prev_key <= i_key;
            // counting stops while the keyboard is locked
            if (key_down && key_released && !i_lock)
                settle_cnt <= held_cnt + 1'b1;
            else
                settle_cnt <= '0;
            if (!key_down)
                key_released <= 1'b1;
            else if (o_kbd_ack)
                key_released <= 1'b0;
        end
    end

    // key encoder
    always_comb begin
        o_cmd.op    = calc_pkg::OP_NONE;
        o_cmd.digit = '0;
        case (i_key)
            kbd_pkg::KEY_NONE:    o_cmd.op = calc_pkg::OP_NONE;
            kbd_pkg::KEY_CLR_ENT: o_cmd.op = calc_pkg::OP_CLR_ENT;
            kbd_pkg::KEY_CLR_ALL: o_cmd.op = calc_pkg::OP_CLR_ALL;
            kbd_pkg::KEY_ENTER:   o_cmd.op = calc_pkg::OP_ENTER;
            kbd_pkg::KEY_ADD:     o_cmd.op = calc_pkg::OP_ADD;
            default: begin
                o_cmd.op    = calc_pkg::OP_DIGIT;
                o_cmd.digit = calc_pkg::digit_t'(i_key - kbd_pkg::KEY_0);
            end
        endcase
    end

endmodule

/* hdl/sequence_control.sv */
// sequence control
// holds a keyed command and runs it over one full delay line revolution

`timescale 1ns/1ps
`include "calc_config.svh"

module sequence_control (
    input  logic              clk,
    input  logic              h_sc_rst,
    input  logic              i_cmd_stb,
    input  calc_pkg::op_cmd_t i_cmd,
    input  calc_pkg::slot_t   i_slot,
    output calc_pkg::op_cmd_t o_active,
    output logic              o_lock
);

    localparam int CNT_W = $clog2(`CALC_DL_LENGTH);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_REV,
        RUN
    } state_e;

    state_e            state;
    calc_pkg::op_cmd_t cmd_q;
    logic [CNT_W-1:0]  slot_cnt;
    logic              run_now;

    // work starts on the rev_start slot itself
    assign run_now = (state == RUN) || ((state == WAIT_REV) && i_slot.rev_start);
    assign o_lock  = (state != IDLE);

    always_comb begin
        o_active = cmd_q;
        if (!run_now) begin
            o_active.op    = calc_pkg::OP_NONE;
            o_active.digit = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (h_sc_rst) begin
            state    <= IDLE;
            slot_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_cmd_stb)
                        state <= WAIT_REV;
                end
                WAIT_REV: begin
                    if (i_slot.rev_start) begin
                        state    <= RUN;
                        slot_cnt <= CNT_W'(1);
                    end
                end
                RUN: begin
                    // home again after the last slot of the revolution
                    if (slot_cnt == CNT_W'(`CALC_DL_LENGTH - 1))
                        state <= IDLE;
                    slot_cnt <= slot_cnt + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd_stb && (state == IDLE))
            cmd_q <= i_cmd;
    end

endmodule

/* hdl/delay_line.sv */
// recirculating digit store
// Johnson coded shift line with its timing chain slot tags

`timescale 1ns/1ps
`include "calc_config.svh"

module delay_line (
    input  logic               clk,
    input  logic               h_sc_rst,
    input  calc_pkg::johnson_t i_wr_code,
    output calc_pkg::johnson_t o_rd_code,
    output calc_pkg::slot_t    o_slot
);

    localparam int SLOT_W = $clog2(`CALC_DL_LENGTH);

    calc_pkg::johnson_t line_q [`CALC_DL_LENGTH];

    // timing chain, register index in bit 0 and column above it
    logic [SLOT_W-1:0] slot_cnt;

    always_ff @(posedge clk) begin
        if (h_sc_rst) begin
            for (int i = 0; i < `CALC_DL_LENGTH; i++) begin
                line_q[i] <= '0;
            end
            slot_cnt <= '0;
        end else begin
            line_q[0] <= i_wr_code;
            for (int i = 1; i < `CALC_DL_LENGTH; i++) begin
                line_q[i] <= line_q[i-1];
            end
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    assign o_rd_code = line_q[`CALC_DL_LENGTH-1];

    // entry digit of a column passes just ahead of its accumulator digit
    always_comb begin
        o_slot.reg_sel   = calc_pkg::reg_sel_e'(slot_cnt[0]);
        o_slot.col       = slot_cnt[SLOT_W-1:1];
        o_slot.rev_start = (slot_cnt == '0);
    end

endmodule

/* hdl/digit_processor.sv */
// serial digit processor
// entry shift, clears, transfer and BCD add applied one slot at a time

`timescale 1ns/1ps
`include "calc_config.svh"

module digit_processor (
    input  logic               clk,
    input  logic               h_sc_rst,
    input  calc_pkg::op_cmd_t  i_active,
    input  calc_pkg::johnson_t i_rd_code,
    input  calc_pkg::slot_t    i_slot,
    output calc_pkg::johnson_t o_wr_code,
    output logic               o_overflow
);

    // all zeros is the code for digit 0
    localparam calc_pkg::johnson_t BLANK = '0;

    calc_pkg::digit_t rd_digit;
    calc_pkg::digit_t prev_entry;
    calc_pkg::digit_t shift_in;
    calc_pkg::digit_t sum_digit;
    logic [4:0]       sum_raw;
    logic             carry_q;
    logic             carry_in;
    logic             carry_out;
    logic             is_entry;
    logic             last_col;

    assign rd_digit = calc_pkg::to_bcd(i_rd_code);
    assign is_entry = (i_slot.reg_sel == calc_pkg::REG_ENTRY);
    assign last_col = (i_slot.col == calc_pkg::col_t'(`CALC_NUM_COLS - 1));

    // keyed digit enters column 0, the rest move up one column
    assign shift_in = (i_slot.col == '0) ? i_active.digit : prev_entry;

    // no carry into the least significant column
    assign carry_in  = (i_slot.col == '0) ? 1'b0 : carry_q;
    assign sum_raw   = 5'(rd_digit) + 5'(prev_entry) + 5'(carry_in);
    assign carry_out = (sum_raw > 5'd9);
    assign sum_digit = carry_out ? calc_pkg::digit_t'(sum_raw - 5'd10) : sum_raw[3:0];

    always_comb begin
        o_wr_code = i_rd_code;
        case (i_active.op)
            calc_pkg::OP_DIGIT: begin
                if (is_entry)
                    o_wr_code = calc_pkg::to_johnson(shift_in);
            end
            calc_pkg::OP_CLR_ENT: begin
                if (is_entry)
                    o_wr_code = BLANK;
            end
            calc_pkg::OP_CLR_ALL: o_wr_code = BLANK;
            calc_pkg::OP_ENTER: begin
                o_wr_code = is_entry ? BLANK : calc_pkg::to_johnson(prev_entry);
            end
            calc_pkg::OP_ADD: begin
                o_wr_code = is_entry ? BLANK : calc_pkg::to_johnson(sum_digit);
            end
            default: o_wr_code = i_rd_code;
        endcase
    end

    // old entry digit, for the next column's shift or this column's accumulator slot
    always_ff @(posedge clk) begin
        if (is_entry)
            prev_entry <= rd_digit;
    end

    always_ff @(posedge clk) begin
        if (h_sc_rst) begin
            carry_q    <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            if ((i_active.op == calc_pkg::OP_ADD) && !is_entry) begin
                carry_q <= carry_out;
                // carry out of the top column lights the lamp
                if (last_col && carry_out)
                    o_overflow <= 1'b1;
            end
            if (i_active.op == calc_pkg::OP_CLR_ALL)
                o_overflow <= 1'b0;
        end
    end

endmodule

/* hdl/register_snapshot.sv */
// register snapshot
// decodes the written delay line stream into BCD copies of both registers

`timescale 1ns/1ps

module register_snapshot (
    input  logic               clk,
    input  logic               h_sc_rst,
    input  calc_pkg::johnson_t i_wr_code,
    input  calc_pkg::slot_t    i_slot,
    output calc_pkg::digits_t  o_entry,
    output calc_pkg::digits_t  o_acc
);

    calc_pkg::johnson_t wr_q;
    calc_pkg::slot_t    slot_q;
    calc_pkg::digit_t   wr_digit;

    assign wr_digit = calc_pkg::to_bcd(wr_q);

    always_ff @(posedge clk) begin
        if (h_sc_rst) begin
            wr_q    <= '0;
            slot_q  <= '0;
            o_entry <= '0;
            o_acc   <= '0;
        end else begin
            wr_q   <= i_wr_code;
            slot_q <= i_slot;
            if (slot_q.reg_sel == calc_pkg::REG_ENTRY)
                o_entry[slot_q.col] <= wr_digit;
            else
                o_acc[slot_q.col] <= wr_digit;
        end
    end

endmodule

/* hdl/ec130_core.sv */
// calculator core top level
// keyboard, sequencing, delay line, digit arithmetic and register readout

`timescale 1ns/1ps

module ec130_core (
    input  logic              clk,
    input  logic              h_sc_rst,
    input  kbd_pkg::key_e     i_key,
    output logic              o_kbd_ack,
    output logic              o_lock,
    output logic              o_overflow,
    output calc_pkg::digits_t o_entry,
    output calc_pkg::digits_t o_acc
);

    calc_pkg::op_cmd_t  key_cmd;
    calc_pkg::op_cmd_t  active_cmd;
    calc_pkg::johnson_t rd_code;
    calc_pkg::johnson_t wr_code;
    calc_pkg::slot_t    slot;

    keyboard_scanner u_keyboard_scanner (
        .clk       (clk),
        .h_sc_rst  (h_sc_rst),
        .i_key     (i_key),
        .i_lock    (o_lock),
        .o_kbd_ack (o_kbd_ack),
        .o_cmd     (key_cmd)
    );

    sequence_control u_sequence_control (
        .clk       (clk),
        .h_sc_rst  (h_sc_rst),
        .i_cmd_stb (o_kbd_ack),
        .i_cmd     (key_cmd),
        .i_slot    (slot),
        .o_active  (active_cmd),
        .o_lock    (o_lock)
    );

    delay_line u_delay_line (
        .clk       (clk),
        .h_sc_rst  (h_sc_rst),
        .i_wr_code (wr_code),
        .o_rd_code (rd_code),
        .o_slot    (slot)
    );

    digit_processor u_digit_processor (
        .clk        (clk),
        .h_sc_rst   (h_sc_rst),
        .i_active   (active_cmd),
        .i_rd_code  (rd_code),
        .i_slot     (slot),
        .o_wr_code  (wr_code),
        .o_overflow (o_overflow)
    );

    register_snapshot u_register_snapshot (
        .clk       (clk),
        .h_sc_rst  (h_sc_rst),
        .i_wr_code (wr_code),
        .i_slot    (slot),
        .o_entry   (o_entry),
        .o_acc     (o_acc)
    );

endmodule

/* verification/tb_ec130.sv */
// testbench for the calculator core
// key press table checked against a whole-register BCD reference model

`timescale 1ns/1ps
`include "calc_config.svh"

module tb_ec130;

    localparam int MAX_HOLD   = `CALC_KEY_DELAY + 4;
    localparam int ROW_CYCLES = MAX_HOLD + 2 * `CALC_DL_LENGTH + 20;
    localparam int LOCK_LIMIT = 2 * `CALC_DL_LENGTH + 4;
    localparam int REG_W      = 4 * `CALC_NUM_COLS;

    typedef struct packed {
        kbd_pkg::key_e     key;
        logic [7:0]        hold;
        calc_pkg::digits_t exp_entry;
        calc_pkg::digits_t exp_acc;
        logic              exp_ovf;
    } row_t;

    logic              clk;
    logic              h_sc_rst;
    kbd_pkg::key_e     i_key;
    logic              o_kbd_ack;
    logic              o_lock;
    logic              o_overflow;
    calc_pkg::digits_t o_entry;
    calc_pkg::digits_t o_acc;

    row_t              rows [$];
    calc_pkg::digits_t m_entry;
    calc_pkg::digits_t m_acc;
    logic              m_ovf;
    integer            seed;
    int                ack_cnt;
    int                err_cnt;
    int                row_errs;
    bit                table_ready;

    ec130_core dut (
        .clk        (clk),
        .h_sc_rst   (h_sc_rst),
        .i_key      (i_key),
        .o_kbd_ack  (o_kbd_ack),
        .o_lock     (o_lock),
        .o_overflow (o_overflow),
        .o_entry    (o_entry),
        .o_acc      (o_acc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ack is combinational, so look once the falling edge inputs have settled
    always @(negedge clk) begin
        #1;
        if (o_kbd_ack)
            ack_cnt++;
    end

    // decimal value of a register, column 0 is the units digit
    function automatic longint unsigned digits_value(input calc_pkg::digits_t r);
        longint unsigned v;
        v = 0;
        for (int i = `CALC_NUM_COLS - 1; i >= 0; i--)
            v = v * 10 + r[i];
        return v;
    endfunction

    // low decimal digits of a value, anything above the top column is dropped
    function automatic calc_pkg::digits_t value_digits(input longint unsigned v);
        calc_pkg::digits_t r;
        for (int i = 0; i < `CALC_NUM_COLS; i++) begin
            r[i] = 4'(v % 10);
            v    = v / 10;
        end
        return r;
    endfunction

    // reference behaviour of one accepted key on whole registers
    task automatic model_key(input kbd_pkg::key_e k);
        longint unsigned sum;
        case (k)
            kbd_pkg::KEY_NONE: ;
            kbd_pkg::KEY_CLR_ENT: m_entry = '0;
            kbd_pkg::KEY_CLR_ALL: begin
                m_entry = '0;
                m_acc   = '0;
                m_ovf   = 1'b0;
            end
            kbd_pkg::KEY_ENTER: begin
                m_acc   = m_entry;
                m_entry = '0;
            end
            kbd_pkg::KEY_ADD: begin
                sum   = digits_value(m_acc) + digits_value(m_entry);
                m_acc = value_digits(sum);
                // a sum too wide for the register is lost and lights the lamp
                if (digits_value(m_acc) != sum)
                    m_ovf = 1'b1;
                m_entry = '0;
            end
            default: m_entry = {m_entry[`CALC_NUM_COLS-2:0], 4'(k - kbd_pkg::KEY_0)};
        endcase
    endtask

    task automatic add_row(input kbd_pkg::key_e k, input int hold);
        row_t r;
        if (hold >= `CALC_KEY_DELAY)
            model_key(k);
        r.key       = k;
        r.hold      = 8'(hold);
        r.exp_entry = m_entry;
        r.exp_acc   = m_acc;
        r.exp_ovf   = m_ovf;
        rows.push_back(r);
    endtask

    task automatic key_in_number(input int n);
        int d;
        int hold;
        for (int i = 0; i < n; i++) begin
            d    = $unsigned($random(seed)) % 10;
            hold = `CALC_KEY_DELAY + $unsigned($random(seed)) % 5;
            add_row(kbd_pkg::key_e'(int'(kbd_pkg::KEY_0) + d), hold);
        end
    endtask

    task automatic build_table();
        m_entry = '0;
        m_acc   = '0;
        m_ovf   = 1'b0;
        add_row(kbd_pkg::KEY_1, 10);
        add_row(kbd_pkg::KEY_2, 10);
        add_row(kbd_pkg::KEY_3, 9);
        // too short to be accepted
        add_row(kbd_pkg::KEY_4, 4);
        add_row(kbd_pkg::KEY_CLR_ENT, 10);
        add_row(kbd_pkg::KEY_7, 8);
        add_row(kbd_pkg::KEY_5, 12);
        add_row(kbd_pkg::KEY_ENTER, 10);
        add_row(kbd_pkg::KEY_9, 10);
        add_row(kbd_pkg::KEY_8, 10);
        add_row(kbd_pkg::KEY_ADD, 10);
        add_row(kbd_pkg::KEY_6, 10);
        add_row(kbd_pkg::KEY_CLR_ENT, 10);
        // all nines plus one wraps to zero
        for (int i = 0; i < `CALC_NUM_COLS; i++)
            add_row(kbd_pkg::KEY_9, 10);
        add_row(kbd_pkg::KEY_ENTER, 10);
        add_row(kbd_pkg::KEY_1, 10);
        add_row(kbd_pkg::KEY_ADD, 10);
        add_row(kbd_pkg::KEY_CLR_ALL, 10);
        for (int n = 0; n < 4; n++) begin
            key_in_number(1 + $unsigned($random(seed)) % `CALC_NUM_COLS);
            add_row(kbd_pkg::KEY_ENTER, 10);
            key_in_number(1 + $unsigned($random(seed)) % `CALC_NUM_COLS);
            add_row(kbd_pkg::KEY_ADD, 11);
        end
        add_row(kbd_pkg::KEY_CLR_ALL, 10);
    endtask

    task automatic check_value(input string name, input logic [REG_W-1:0] got,
                               input logic [REG_W-1:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
            row_errs++;
        end
    endtask

    task automatic check_reset();
        row_errs = 0;
        check_value("o_lock", o_lock, 0);
        check_value("o_kbd_ack", o_kbd_ack, 0);
        check_value("o_overflow", o_overflow, 0);
        check_value("o_entry", o_entry, 0);
        check_value("o_acc", o_acc, 0);
        $display("reset state: %s", (row_errs == 0) ? "ok" : "mismatch");
    endtask

    task automatic apply_row(input int idx);
        row_t          r;
        kbd_pkg::key_e k;
        int            waited;
        r        = rows[idx];
        k        = r.key;
        row_errs = 0;
        ack_cnt  = 0;
        i_key    = k;
        repeat (r.hold) @(negedge clk);
        i_key  = kbd_pkg::KEY_NONE;
        waited = 0;
        while (o_lock && (waited < LOCK_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        assert (!o_lock) else begin
            $display("lock still high %0d cycles after key %s was released",
                     LOCK_LIMIT, k.name());
            err_cnt++;
            row_errs++;
        end
        // snapshot follows one cycle after the lock drops
        @(negedge clk);
        check_value("o_kbd_ack count", ack_cnt, (r.hold >= `CALC_KEY_DELAY) ? 1 : 0);
        check_value("o_entry", o_entry, r.exp_entry);
        check_value("o_acc", o_acc, r.exp_acc);
        check_value("o_overflow", o_overflow, r.exp_ovf);
        $display("row %0d key %s hold %0d: %s", idx, k.name(), r.hold,
                 (row_errs == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        seed        = 32'h9c63_d9e2;
        err_cnt     = 0;
        ack_cnt     = 0;
        row_errs    = 0;
        table_ready = 1'b0;
        h_sc_rst    = 1'b1;
        i_key       = kbd_pkg::KEY_NONE;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(negedge clk);
        h_sc_rst = 1'b0;
        @(negedge clk);
        check_reset();
        foreach (rows[i])
            apply_row(i);
        $display("%0d rows applied, %0d errors", rows.size(), err_cnt);
        if (err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // watchdog sized from the table once it is built
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * ROW_CYCLES + 20;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d clock cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/calc_pkg.sv
hdl/kbd_pkg.sv
hdl/keyboard_scanner.sv
hdl/sequence_control.sv
hdl/delay_line.sv
hdl/digit_processor.sv
hdl/register_snapshot.sv
hdl/ec130_core.sv
verification/tb_ec130.sv

/* Bender.yml */
package:
  name: ec130

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/calc_pkg.sv
      - hdl/kbd_pkg.sv
      - hdl/keyboard_scanner.sv
      - hdl/sequence_control.sv
      - hdl/delay_line.sv
      - hdl/digit_processor.sv
      - hdl/register_snapshot.sv
      - hdl/ec130_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/tb_ec130.sv
